// ==== rtl/decodePkg.sv ====
// Decode package: widths, field positions, opcode and function codes, register and immediate types
package decodePkg;

	// ==============================
	// Widths
	localparam int INSTR_WIDTH = 36;
	localparam int VALUE_WIDTH = 64;
	localparam int ADDR_WIDTH = 32;
	localparam int LSM_MASK_WIDTH = 36;
	localparam int REG_IDX_WIDTH = 6;

	// ==============================
	// Instruction field positions
	localparam int OP_LO = 0;
	localparam int OP_HI = 7;
	localparam int RT_LO = 8;
	localparam int RT_HI = 13;
	localparam int RA_LO = 14;
	localparam int RA_HI = 19;
	localparam int RB_LO = 20;
	localparam int RB_HI = 25;
	localparam int FUNC_LO = 30;		// R2 function
	localparam int FUNC_HI = 35;
	localparam int LSFUNC_LO = 32;		// Load/store function
	localparam int LSFUNC_HI = 35;

	// Mask bits 2 to 7 never name a register
	localparam int LSM_GAP_LO = 2;
	localparam int LSM_GAP_HI = 7;

	typedef logic [INSTR_WIDTH-1:0] instrT;
	typedef logic [REG_IDX_WIDTH-1:0] regIdxT;
	typedef logic [VALUE_WIDTH-1:0] valueT;
	typedef logic [ADDR_WIDTH-1:0] addressT;

	// ==============================
	// Opcodes
	localparam logic [7:0] BRK = 8'h00;
	localparam logic [7:0] NOP = 8'h01;
	localparam logic [7:0] R2 = 8'h02;
	localparam logic [7:0] ADDI = 8'h04;
	localparam logic [7:0] MULI = 8'h06;
	localparam logic [7:0] ANDI = 8'h08;
	localparam logic [7:0] ORI = 8'h09;
	localparam logic [7:0] XORI = 8'h0A;
	localparam logic [7:0] SLTI = 8'h0C;
	localparam logic [7:0] SLTUI = 8'h0D;
	localparam logic [7:0] JAL = 8'h40;
	localparam logic [7:0] BEQ = 8'h48;
	localparam logic [7:0] BNE = 8'h49;
	localparam logic [7:0] BLTU = 8'h4C;
	localparam logic [7:0] LDX = 8'h60;
	localparam logic [7:0] STX = 8'h68;
	localparam logic [3:0] COMPACT_GROUP = 4'h7;	// Upper opcode nibble
	localparam logic [3:0] LSM_FUNC = 4'hF;

	// R2 functions
	localparam logic [5:0] ADD = 6'h04;
	localparam logic [5:0] SUB = 6'h05;
	localparam logic [5:0] AND = 6'h08;
	localparam logic [5:0] OR = 6'h09;
	localparam logic [5:0] XOR = 6'h0A;
	localparam logic [5:0] SLT = 6'h10;
	localparam logic [5:0] SLTU = 6'h11;
	localparam logic [5:0] MUL = 6'h18;
	localparam logic [5:0] DIV = 6'h1C;
	localparam logic [5:0] SLLI = 6'h20;

	localparam regIdxT FP_REG = 6'd29;	// Frame pointer
	localparam regIdxT SP_REG = 6'd30;	// Stack pointer

	// How the 64-bit immediate is built
	typedef enum logic [3:0] {
		IMM_NONE = 4'd0,
		IMM_SEXT16 = 4'd1,
		IMM_ZEXT16 = 4'd2,
		IMM_ONES16 = 4'd3,
		IMM_SHAMT = 4'd4,
		IMM_LOAD12 = 4'd5,
		IMM_STORE12 = 4'd6,
		IMM_BRANCH16 = 4'd7,
		IMM_JUMP26 = 4'd8,
		IMM_CSCALED = 4'd9,
		IMM_CSEXT7 = 4'd10,
		IMM_CSEXT10 = 4'd11,
		IMM_CSEXT5 = 4'd12
	} immKindT;

endpackage

// ==== rtl/decodeCtrlIf.sv ====
// Decoder control interface: register selection, immediate kind and decode flags
interface decodeCtrlIf;
	import decodePkg::*;

	regIdxT rt;
	regIdxT ra;
	regIdxT rb;
	immKindT immKind;
	logic rfwr;		// Register file write
	logic mc;		// Multi-cycle op
	logic lsm;		// Load/store multiple
	logic branch;
	logic needRb;
	logic isSigned;
	logic memOp;
	logic unimpl;

	modport producer (
		output rt, ra, rb, immKind,
		output rfwr, mc, lsm, branch, needRb, isSigned, memOp, unimpl
	);

	modport consumer (
		input rt, ra, rb, immKind,
		input rfwr, mc, lsm, branch, needRb, isSigned, memOp, unimpl
	);

endinterface

// ==== rtl/registerListPick.sv ====
// Load/store-multiple register pick: first register named by the mask
module registerListPick (
	input logic [decodePkg::LSM_MASK_WIDTH-1:0] lsmMask,
	output decodePkg::regIdxT firstReg
);
	import decodePkg::*;

	// Eligible bits are numbered from 1, skipping the gap
	always_comb begin : scanMask
		logic found;
		regIdxT regNum;
		found = 1'b0;
		regNum = '0;
		firstReg = '0;		// No register named
		for (int n = 0; n < LSM_MASK_WIDTH; n++) begin
			if (n < LSM_GAP_LO || n > LSM_GAP_HI) begin
				regNum = regNum + 1'b1;
				if (lsmMask[n] && !found) begin
					firstReg = regNum;
					found = 1'b1;
				end
			end
		end
	end

endmodule

// ==== rtl/wideDecode.sv ====
// Full-length decoder: opcode and R2 function decode into the control interface
module wideDecode (
	input decodePkg::instrT instr,
	input decodePkg::regIdxT firstReg,
	decodeCtrlIf.producer ctrl
);
	import decodePkg::*;

	logic [7:0] opcode;
	logic [5:0] func;
	logic [3:0] lsFunc;
	regIdxT rtField;
	logic isLsm;

	assign opcode = instr[OP_HI:OP_LO];
	assign func = instr[FUNC_HI:FUNC_LO];
	assign lsFunc = instr[LSFUNC_HI:LSFUNC_LO];
	assign rtField = instr[RT_HI:RT_LO];
	assign isLsm = lsFunc == LSM_FUNC;

	always_comb begin
		// Defaults: unimplemented, no write
		ctrl.rt = '0;
		ctrl.ra = instr[RA_HI:RA_LO];
		ctrl.rb = instr[RB_HI:RB_LO];
		ctrl.immKind = IMM_NONE;
		ctrl.rfwr = 1'b0;
		ctrl.mc = 1'b0;
		ctrl.lsm = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.needRb = 1'b0;
		ctrl.isSigned = 1'b1;
		ctrl.memOp = 1'b0;
		ctrl.unimpl = 1'b1;

		case (opcode)
		BRK, NOP:
			ctrl.unimpl = 1'b0;

		// ==============================
		// Register-register ALU
		R2:
			case (func)
			ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL, DIV, SLLI: begin
				ctrl.rt = rtField;
				ctrl.rfwr = 1'b1;
				ctrl.needRb = 1'b1;
				ctrl.unimpl = 1'b0;
				ctrl.mc = (func == MUL) || (func == DIV);
				ctrl.isSigned = func != SLTU;
				if (func == SLLI)
					ctrl.immKind = IMM_SHAMT;	// Shift amount in rb field
			end
			default: ;
			endcase

		// ==============================
		// Immediate ALU
		ADDI, MULI, ANDI, ORI, XORI, SLTI, SLTUI: begin
			ctrl.rt = rtField;
			ctrl.rfwr = 1'b1;
			ctrl.unimpl = 1'b0;
			ctrl.mc = opcode == MULI;
			ctrl.isSigned = opcode != SLTUI;
			case (opcode)
			ANDI: ctrl.immKind = IMM_ONES16;	// Keeps upper bits of ra
			ORI, XORI, SLTUI: ctrl.immKind = IMM_ZEXT16;
			default: ctrl.immKind = IMM_SEXT16;
			endcase
		end

		// ==============================
		// Flow control
		JAL: begin
			ctrl.rt = {4'd0, instr[9:8]};	// Link register
			ctrl.rfwr = 1'b1;
			ctrl.mc = 1'b1;
			ctrl.immKind = IMM_JUMP26;
			ctrl.unimpl = 1'b0;
		end
		BEQ, BNE, BLTU: begin
			ctrl.branch = 1'b1;
			ctrl.needRb = 1'b1;
			ctrl.mc = 1'b1;
			ctrl.immKind = IMM_BRANCH16;
			ctrl.isSigned = opcode != BLTU;
			ctrl.unimpl = 1'b0;
		end

		// ==============================
		// Memory
		LDX: begin
			ctrl.memOp = 1'b1;
			ctrl.mc = 1'b1;
			ctrl.rfwr = 1'b1;
			ctrl.immKind = IMM_LOAD12;
			ctrl.lsm = isLsm;
			ctrl.rt = isLsm ? firstReg : rtField;
			ctrl.unimpl = 1'b0;
		end
		STX: begin
			ctrl.memOp = 1'b1;
			ctrl.mc = 1'b1;
			ctrl.needRb = 1'b1;
			ctrl.immKind = IMM_STORE12;		// Displacement split around rt field
			ctrl.lsm = isLsm;
			if (isLsm)
				ctrl.rb = firstReg;
			ctrl.unimpl = 1'b0;
		end
		default: ;
		endcase
	end

endmodule

// ==== rtl/compactDecode.sv ====
// Compact-form decoder: opcodes 0x70 to 0x7F into the control interface
module compactDecode (
	input decodePkg::instrT instr,
	decodeCtrlIf.producer ctrl
);
	import decodePkg::*;

	logic [3:0] subOp;
	regIdxT reg5;

	assign subOp = instr[3:0];
	assign reg5 = {1'b0, instr[12:8]};

	// Three-bit choice set onto the common registers
	function automatic regIdxT choiceReg(input logic [2:0] sel);
		case (sel)
		3'd0: choiceReg = 6'd1;		// Return address
		3'd1: choiceReg = 6'd4;
		3'd2: choiceReg = 6'd5;
		3'd3: choiceReg = 6'd10;	// Saved
		3'd4: choiceReg = 6'd11;
		3'd5: choiceReg = 6'd20;	// Arguments
		3'd6: choiceReg = 6'd21;
		default: choiceReg = 6'd22;
		endcase
	endfunction

	always_comb begin
		ctrl.rt = '0;
		ctrl.ra = '0;			// Unused operands read r0
		ctrl.rb = '0;
		ctrl.immKind = IMM_NONE;
		ctrl.rfwr = 1'b0;
		ctrl.mc = 1'b0;
		ctrl.lsm = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.needRb = 1'b0;
		ctrl.isSigned = 1'b1;
		ctrl.memOp = 1'b0;
		ctrl.unimpl = subOp == 4'd13;	// Only 13 is reserved

		case (subOp)
		// Frame/stack relative load and store; 0 with r0 is a break
		4'd0, 4'd1, 4'd2, 4'd3:
			if (subOp != 4'd0 || reg5 != '0) begin
				ctrl.ra = subOp[0] ? SP_REG : FP_REG;
				ctrl.memOp = 1'b1;
				ctrl.immKind = IMM_CSCALED;
				if (subOp[1])
					ctrl.rb = reg5;		// Store data
				else begin
					ctrl.rt = reg5;
					ctrl.rfwr = 1'b1;
				end
			end
		4'd5, 4'd6, 4'd7: begin			// Short add
			ctrl.rt = reg5;
			ctrl.ra = reg5;
			ctrl.rfwr = 1'b1;
			ctrl.immKind = (reg5 == SP_REG) ? IMM_CSCALED : IMM_CSEXT7;
		end
		4'd10: begin					// Branch and link
			ctrl.rt = {4'd0, instr[9:8]};
			ctrl.rfwr = 1'b1;
			ctrl.mc = 1'b1;
			ctrl.immKind = IMM_CSEXT10;
		end
		4'd11: begin					// Load immediate
			ctrl.rt = reg5;
			ctrl.rfwr = 1'b1;
			ctrl.immKind = IMM_CSEXT7;
		end
		4'd12:
			if (instr[19:18] == 2'b11) begin
				ctrl.rt = choiceReg(instr[10:8]);
				ctrl.ra = choiceReg(instr[10:8]);
				ctrl.rb = choiceReg(instr[15:13]);
				ctrl.needRb = 1'b1;
				ctrl.rfwr = 1'b1;
			end else begin
				ctrl.rt = reg5;
				ctrl.ra = reg5;
				ctrl.rfwr = 1'b1;
				ctrl.immKind = IMM_CSEXT5;
			end
		default: ;
		endcase
	end

endmodule

// ==== rtl/immediateExtract.sv ====
// Immediate extraction: 64-bit immediate from the instruction and an immediate kind
module immediateExtract (
	input decodePkg::instrT instr,
	input decodePkg::immKindT immKind,
	output decodePkg::valueT imm
);
	import decodePkg::*;

	always_comb begin
		case (immKind)
		IMM_SEXT16:
			imm = {{VALUE_WIDTH-16{instr[35]}}, instr[35:20]};
		IMM_ZEXT16:
			imm = {{VALUE_WIDTH-16{1'b0}}, instr[35:20]};
		IMM_ONES16:
			imm = {{VALUE_WIDTH-16{1'b1}}, instr[35:20]};
		IMM_SHAMT:
			imm = {{VALUE_WIDTH-6{1'b0}}, instr[25:20]};
		IMM_LOAD12:
			imm = {{VALUE_WIDTH-12{instr[31]}}, instr[31:20]};
		IMM_STORE12:		// Upper six above rb, lower six in rt slot
			imm = {{VALUE_WIDTH-12{instr[31]}}, instr[31:26], instr[13:8]};
		IMM_BRANCH16:
			imm = {{VALUE_WIDTH-16{instr[35]}}, instr[35:26], instr[13:8]};
		IMM_JUMP26:
			imm = {{VALUE_WIDTH-26{instr[35]}}, instr[35:10]};
		IMM_CSCALED:		// Word scaled offset
			imm = {{VALUE_WIDTH-10{instr[19]}}, instr[19:13], 3'b000};
		IMM_CSEXT7:
			imm = {{VALUE_WIDTH-7{instr[19]}}, instr[19:13]};
		IMM_CSEXT10:
			imm = {{VALUE_WIDTH-10{instr[19]}}, instr[19:10]};
		IMM_CSEXT5:
			imm = {{VALUE_WIDTH-5{instr[17]}}, instr[17:13]};
		default:
			imm = '0;
		endcase
	end

endmodule

// ==== rtl/decodeRegister.sv ====
// Decode register: compact or full selection, immediate forming and the registered record
module decodeRegister (
	input logic clk,
	input logic rst,
	input logic inValid,
	input decodePkg::instrT instr,
	input decodePkg::addressT predictedIp,
	decodeCtrlIf.consumer wideCtrl,
	decodeCtrlIf.consumer compactCtrl,
	output logic outValid,
	output decodePkg::addressT pip,
	output decodePkg::regIdxT rt,
	output decodePkg::regIdxT ra,
	output decodePkg::regIdxT rb,
	output decodePkg::valueT imm,
	output logic rfwr,
	output logic mc,
	output logic lsm,
	output logic branch,
	output logic needRb,
	output logic isSigned,
	output logic memOp,
	output logic unimpl
);
	import decodePkg::*;

	logic isCompact;
	immKindT immKind;
	valueT immValue;
	logic [7:0] wideFlags;
	logic [7:0] compactFlags;
	logic [7:0] flagReg;

	assign isCompact = instr[OP_HI -: 4] == COMPACT_GROUP;
	assign immKind = isCompact ? compactCtrl.immKind : wideCtrl.immKind;

	assign wideFlags = {wideCtrl.rfwr, wideCtrl.mc, wideCtrl.lsm, wideCtrl.branch,
		wideCtrl.needRb, wideCtrl.isSigned, wideCtrl.memOp, wideCtrl.unimpl};
	assign compactFlags = {compactCtrl.rfwr, compactCtrl.mc, compactCtrl.lsm,
		compactCtrl.branch, compactCtrl.needRb, compactCtrl.isSigned,
		compactCtrl.memOp, compactCtrl.unimpl};
	assign {rfwr, mc, lsm, branch, needRb, isSigned, memOp, unimpl} = flagReg;

	immediateExtract immediateExtract_i (
		.instr(instr),
		.immKind(immKind),
		.imm(immValue)
	);

	// ==============================
	// Control state
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			flagReg <= '0;
		end else begin
			outValid <= inValid;
			if (inValid)
				flagReg <= isCompact ? compactFlags : wideFlags;
		end
	end

	// Record fields hold while idle
	always_ff @(posedge clk) begin
		if (inValid) begin
			pip <= predictedIp;
			rt <= isCompact ? compactCtrl.rt : wideCtrl.rt;
			ra <= isCompact ? compactCtrl.ra : wideCtrl.ra;
			rb <= isCompact ? compactCtrl.rb : wideCtrl.rb;
			imm <= immValue;
		end
	end

endmodule

// ==== rtl/decodeTop.sv ====
// Decode stage top level: register-list pick, full and compact decoders, decode register
module decodeTop (
	input logic clk,
	input logic rst,
	input logic inValid,
	input decodePkg::instrT instr,
	input decodePkg::addressT predictedIp,
	input logic [decodePkg::LSM_MASK_WIDTH-1:0] lsmMask,
	output logic outValid,
	output decodePkg::addressT pip,
	output decodePkg::regIdxT rt,
	output decodePkg::regIdxT ra,
	output decodePkg::regIdxT rb,
	output decodePkg::valueT imm,
	output logic rfwr,
	output logic mc,
	output logic lsm,
	output logic branch,
	output logic needRb,
	output logic isSigned,
	output logic memOp,
	output logic unimpl
);
	import decodePkg::*;

	regIdxT firstReg;		// From the load/store-multiple mask

	decodeCtrlIf wideCtrl ();
	decodeCtrlIf compactCtrl ();

	registerListPick registerListPick_i (
		.lsmMask(lsmMask),
		.firstReg(firstReg)
	);

	wideDecode wideDecode_i (
		.instr(instr),
		.firstReg(firstReg),
		.ctrl(wideCtrl)
	);

	compactDecode compactDecode_i (
		.instr(instr),
		.ctrl(compactCtrl)
	);

	decodeRegister decodeRegister_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.predictedIp(predictedIp),
		.wideCtrl(wideCtrl),
		.compactCtrl(compactCtrl),
		.outValid(outValid),
		.pip(pip),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.rfwr(rfwr),
		.mc(mc),
		.lsm(lsm),
		.branch(branch),
		.needRb(needRb),
		.isSigned(isSigned),
		.memOp(memOp),
		.unimpl(unimpl)
	);

endmodule

// ==== testbench/decodeVectors.svh ====
// Decode vector table: row layout, row count and the rows with expected decode records
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
	logic valid;
	instrT instr;
	instrT freeBits;						// Bits that get random values
	logic [LSM_MASK_WIDTH-1:0] mask;
	regIdxT rt;
	regIdxT ra;
	regIdxT rb;
	valueT imm;
	logic [7:0] flags;						// rfwr mc lsm branch needRb isSigned memOp unimpl
} vectorT;

localparam int NUM_ROWS = 28;

localparam vectorT VECTORS [NUM_ROWS] = '{
	// ==============================
	// Register-register and immediate ALU
	'{1'b1, {ADD, 4'h0, 6'd3, 6'd2, 6'd1, R2}, 36'h03C000000, 36'h0,
		6'd1, 6'd2, 6'd3, 64'h0, 8'b1000_1100},
	'{1'b1, {SLTU, 4'h0, 6'd9, 6'd8, 6'd7, R2}, 36'h03C000000, 36'h0,
		6'd7, 6'd8, 6'd9, 64'h0, 8'b1000_1000},
	'{1'b1, {MUL, 4'h0, 6'd12, 6'd11, 6'd10, R2}, 36'h03C000000, 36'h0,
		6'd10, 6'd11, 6'd12, 64'h0, 8'b1100_1100},
	'{1'b1, {SLLI, 4'h0, 6'd5, 6'd4, 6'd6, R2}, 36'h03C000000, 36'h0,
		6'd6, 6'd4, 6'd5, 64'h5, 8'b1000_1100},
	'{1'b1, {16'hFFF0, 6'd20, 6'd21, ADDI}, 36'h0, 36'h0,
		6'd21, 6'd20, 6'd48, 64'hFFFF_FFFF_FFFF_FFF0, 8'b1000_0100},
	'{1'b1, {16'h8001, 6'd1, 6'd2, ANDI}, 36'h0, 36'h0,
		6'd2, 6'd1, 6'd1, 64'hFFFF_FFFF_FFFF_8001, 8'b1000_0100},
	'{1'b1, {16'h9234, 6'd3, 6'd4, ORI}, 36'h0, 36'h0,
		6'd4, 6'd3, 6'd52, 64'h9234, 8'b1000_0100},
	'{1'b1, {16'hC000, 6'd5, 6'd6, SLTUI}, 36'h0, 36'h0,
		6'd6, 6'd5, 6'd0, 64'hC000, 8'b1000_0000},
	// ==============================
	// Jump and branches
	'{1'b1, {26'h3FFFFFE, 2'd2, JAL}, 36'h0, 36'h0,
		6'd2, 6'd63, 6'd63, 64'hFFFF_FFFF_FFFF_FFFE, 8'b1100_0100},
	'{1'b1, {10'h3FF, 6'd2, 6'd1, 6'h3C, BEQ}, 36'h0, 36'h0,
		6'd0, 6'd1, 6'd2, 64'hFFFF_FFFF_FFFF_FFFC, 8'b0101_1100},
	'{1'b1, {10'h001, 6'd4, 6'd3, 6'h05, BLTU}, 36'h0, 36'h0,
		6'd0, 6'd3, 6'd4, 64'h45, 8'b0101_1000},
	// ==============================
	// Loads and stores, plain and multiple
	'{1'b1, {4'h2, 12'hF80, 6'd9, 6'd10, LDX}, 36'h0, 36'h0,
		6'd10, 6'd9, 6'd0, 64'hFFFF_FFFF_FFFF_FF80, 8'b1100_0110},
	'{1'b1, {4'hF, 12'h010, 6'd9, 6'd10, LDX}, 36'h0, 36'h0,
		6'd0, 6'd9, 6'd16, 64'h10, 8'b1110_0110},
	'{1'b1, {4'hF, 12'h004, 6'd1, 6'd7, LDX}, 36'h0, 36'h2,
		6'd2, 6'd1, 6'd4, 64'h4, 8'b1110_0110},
	'{1'b1, {4'hF, 12'h000, 6'd2, 6'd5, LDX}, 36'h0, 36'h210,	// Bit 4 sits in the gap
		6'd4, 6'd2, 6'd0, 64'h0, 8'b1110_0110},
	'{1'b1, {4'h0, 6'h21, 6'd7, 6'd8, 6'h0F, STX}, 36'h0, 36'h0,
		6'd0, 6'd8, 6'd7, 64'hFFFF_FFFF_FFFF_F84F, 8'b0100_1110},
	'{1'b1, {4'hF, 6'h02, 6'd7, 6'd8, 6'h01, STX}, 36'h0, 36'h8_0000_0000,
		6'd0, 6'd8, 6'd30, 64'h81, 8'b0110_1110},
	// Idle slot, the record holds
	'{1'b0, 36'h0, 36'hFFFFFFFFF, 36'h0,
		6'd0, 6'd8, 6'd30, 64'h81, 8'b0110_1110},
	// ==============================
	// Compact forms
	'{1'b1, {16'h0000, 7'h7F, 5'd5, 8'h70}, 36'hFFFF00000, 36'h0,
		6'd5, 6'd29, 6'd0, 64'hFFFF_FFFF_FFFF_FFF8, 8'b1000_0110},
	'{1'b1, {16'h0000, 7'h02, 5'd12, 8'h73}, 36'hFFFF00000, 36'h0,
		6'd0, 6'd30, 6'd12, 64'h10, 8'b0000_0110},
	'{1'b1, {16'h0000, 7'h7E, 5'd30, 8'h75}, 36'hFFFF00000, 36'h0,
		6'd30, 6'd30, 6'd0, 64'hFFFF_FFFF_FFFF_FFF0, 8'b1000_0100},
	'{1'b1, {16'h0000, 7'h7E, 5'd8, 8'h76}, 36'hFFFF00000, 36'h0,
		6'd8, 6'd8, 6'd0, 64'hFFFF_FFFF_FFFF_FFFE, 8'b1000_0100},
	'{1'b1, {16'h0000, 10'h201, 2'd1, 8'h7A}, 36'hFFFF00000, 36'h0,
		6'd1, 6'd0, 6'd0, 64'hFFFF_FFFF_FFFF_FE01, 8'b1100_0100},
	'{1'b1, {16'h0000, 2'b11, 2'b00, 3'd5, 2'b00, 3'd3, 8'h7C}, 36'hFFFF00000, 36'h0,
		6'd10, 6'd10, 6'd20, 64'h0, 8'b1000_1100},
	'{1'b1, {16'h0000, 2'b01, 5'h11, 5'd6, 8'h7C}, 36'hFFFF00000, 36'h0,
		6'd6, 6'd6, 6'd0, 64'hFFFF_FFFF_FFFF_FFF1, 8'b1000_0100},
	// ==============================
	// Unknown opcodes and functions
	'{1'b1, {28'h0, 8'h7D}, 36'hFFFFFFF00, 36'h0,
		6'd0, 6'd0, 6'd0, 64'h0, 8'b0000_0101},
	'{1'b1, {10'h000, 6'd4, 6'd3, 6'd2, 8'h03}, 36'hFFC003F00, 36'h0,
		6'd0, 6'd3, 6'd4, 64'h0, 8'b0000_0101},
	'{1'b1, {6'h3F, 4'h0, 6'd1, 6'd2, 6'd3, R2}, 36'h03C000000, 36'h0,
		6'd0, 6'd2, 6'd1, 64'h0, 8'b0000_0101}
};

`endif

// ==== testbench/decodeTopTb.sv ====
// Decode stage testbench: clock, reset, table-driven stimulus loop, record compare and watchdog
module decodeTopTb;
	import decodePkg::*;

	localparam int PERIOD = 40;
	localparam int DRIVE_DELAY = 2;		// After the rising edge

	`include "decodeVectors.svh"

	logic clk;
	logic rst;
	logic inValid;
	instrT instr;
	addressT predictedIp;
	logic [LSM_MASK_WIDTH-1:0] lsmMask;
	logic outValid;
	addressT pip;
	regIdxT rt;
	regIdxT ra;
	regIdxT rb;
	valueT imm;
	logic rfwr;
	logic mc;
	logic lsm;
	logic branch;
	logic needRb;
	logic isSigned;
	logic memOp;
	logic unimpl;

	// Expected record, held across idle slots
	logic expValid;
	addressT expPip;
	regIdxT expRt;
	regIdxT expRa;
	regIdxT expRb;
	valueT expImm;
	logic [7:0] expFlags;

	decodeTop decodeTop_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.predictedIp(predictedIp),
		.lsmMask(lsmMask),
		.outValid(outValid),
		.pip(pip),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.rfwr(rfwr),
		.mc(mc),
		.lsm(lsm),
		.branch(branch),
		.needRb(needRb),
		.isSigned(isSigned),
		.memOp(memOp),
		.unimpl(unimpl)
	);

	always #(PERIOD / 2) clk = ~clk;

	// ==============================
	// Compare and stimulus tasks
	task automatic compareValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Test failures found");
			$fatal(1, "Decode record mismatch");
		end
	endtask

	task automatic checkRecord();
		compareValue("outValid", 64'(outValid), 64'(expValid));
		compareValue("pip", 64'(pip), 64'(expPip));
		compareValue("rt", 64'(rt), 64'(expRt));
		compareValue("ra", 64'(ra), 64'(expRa));
		compareValue("rb", 64'(rb), 64'(expRb));
		compareValue("imm", imm, expImm);
		compareValue("rfwr", 64'(rfwr), 64'(expFlags[7]));
		compareValue("mc", 64'(mc), 64'(expFlags[6]));
		compareValue("lsm", 64'(lsm), 64'(expFlags[5]));
		compareValue("branch", 64'(branch), 64'(expFlags[4]));
		compareValue("needRb", 64'(needRb), 64'(expFlags[3]));
		compareValue("isSigned", 64'(isSigned), 64'(expFlags[2]));
		compareValue("memOp", 64'(memOp), 64'(expFlags[1]));
		compareValue("unimpl", 64'(unimpl), 64'(expFlags[0]));
	endtask

	task automatic applyRow(input vectorT row);
		instrT fill;
		fill = instrT'({$urandom(), $urandom()});
		inValid = row.valid;
		instr = (row.instr & ~row.freeBits) | (fill & row.freeBits);
		lsmMask = row.mask;
		predictedIp = $urandom();
		expValid = row.valid;
		if (row.valid) begin			// Idle rows keep the last record
			expPip = predictedIp;
			expRt = row.rt;
			expRa = row.ra;
			expRb = row.rb;
			expImm = row.imm;
			expFlags = row.flags;
		end
	endtask

	// ==============================
	// Main flow
	initial begin : mainFlow
		int row;
		void'($urandom(13));
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		instr = '0;
		predictedIp = '0;
		lsmMask = '0;
		expValid = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		compareValue("outValid", 64'(outValid), 64'h0);
		compareValue("flags", 64'({rfwr, mc, lsm, branch, needRb, isSigned, memOp, unimpl}),
			64'h0);

		// One row per clock, checked at the next edge
		for (row = 0; row < NUM_ROWS; row++) begin
			applyRow(VECTORS[row]);
			@(posedge clk);
			#DRIVE_DELAY;
			checkRecord();
		end

		$display("All tests passed!");
		$finish;
	end

	initial begin : watchdog
		#((NUM_ROWS + 10) * PERIOD);
		$display("Timeout: the decode run did not finish in time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== sim.f ====
+incdir+testbench
rtl/decodePkg.sv
rtl/decodeCtrlIf.sv
rtl/registerListPick.sv
rtl/wideDecode.sv
rtl/compactDecode.sv
rtl/immediateExtract.sv
rtl/decodeRegister.sv
rtl/decodeTop.sv
testbench/decodeTopTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module decodeTopTb -f sim.f -o decodeSim
./obj_dir/decodeSim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
